// ==== Bender.yml ====
package:
  name: gs_solver

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/gs_num_pkg.sv
      - verilog/gs_ctrl_pkg.sv
      - verilog/gs_fsm.sv
      - verilog/gs_index_counter.sv
      - verilog/gs_row_unit.sv
      - verilog/gs_vector_store.sv
      - verilog/gs_top.sv
  - target: test
    files:
      - test/tb_gs_mem.sv
      - test/tb_gs_top.sv

// ==== filelist.f ====
+incdir+verilog
verilog/gs_num_pkg.sv
verilog/gs_ctrl_pkg.sv
verilog/gs_fsm.sv
verilog/gs_index_counter.sv
verilog/gs_row_unit.sv
verilog/gs_vector_store.sv
verilog/gs_top.sv
test/tb_gs_mem.sv
test/tb_gs_top.sv

// ==== test/gs_testdata.hex ====
// lines 0-33: memory words, lane 15 on the left, 17 per system (b word, then rows 0-15)
// lines 34-65: expected Q16.16 results for result addresses 0-31
// system 0: lower triangular, reciprocals 1.0, 0.5, -1.0, 0.25 and 2^-14
000F_000E_000D_000C_000B_000A_0000_0014_FC18_0000_0001_0064_0007_FFFD_000A_0005
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0001
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0002_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_2000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_FFFF_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_C000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0003_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_1000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_4000_0001_0000_0000_0000_0000_0000_0000_0000_0001
0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0001_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
4000_0002_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
FFF1_000E_0100_000C_000B_0003_0009_0008_0007_0006_0000_FFFE_0002_0001_8000_7FFF
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_7FFF
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_7FFF_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_FFFC_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_6000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0001_0001_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_0000_2000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
0000_4000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
4000_0000_0000_0000_0000_0002_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
00050000
00050000
FFF30000
00038000
00678000
FFFF0000
00030000
FC180000
00050000
FFF60000
000A0000
000B0000
00000030
000D0000
000E0000
FFF30000
7FFFFFFF
80000000
00010000
00060000
FFFD0000
FFFD0000
00060000
00070000
00080000
00090000
00018000
000B0000
000C0000
01000000
000E0000
FFEE0000

// ==== test/tb_gs_mem.sv ====
// matrix memory model
`timescale 1ns/1ps
`default_nettype none

module tb_gs_mem (
	input  logic         i_clk,
	input  logic         i_rreq,
	input  logic [9:0]   i_addr,
	output logic [255:0] o_dout,
	output logic         o_dout_vld,
	output logic         o_busy // read outstanding
);

	logic [255:0] words [0:33]; // filled by the testbench top
	logic [31:0]  lfsr_state;
	int           wait_cnt;
	logic [9:0]   addr_q;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		lfsr_next = {s[30:0], fb};
	endfunction

	initial begin
		lfsr_state = 32'hd20c;
		o_dout     = '0;
		o_dout_vld = 1'b0;
		o_busy     = 1'b0;
		wait_cnt   = 0;
		addr_q     = '0;
	end

	// ------------------------------------------------------------
	// one read at a time, latency 1 to 4 cycles
	// ------------------------------------------------------------
	always @(negedge i_clk) begin
		logic [1:0] lat;
		o_dout_vld <= 1'b0;
		if (o_busy) begin
			if (wait_cnt == 1) begin
				o_dout     <= words[addr_q];
				o_dout_vld <= 1'b1;
				o_busy     <= 1'b0;
			end
			wait_cnt <= wait_cnt - 1;
		end else if (i_rreq) begin
			lfsr_state = lfsr_next(lfsr_state);
			lat[0]     = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			lat[1]     = lfsr_state[0];
			wait_cnt   <= int'(lat) + 1;
			addr_q     <= i_addr;
			o_busy     <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_gs_top.sv ====
// Gauss-Seidel solver testbench
`timescale 1ns/1ps
`default_nettype none
`include "gs_macros.svh"

module tb_gs_top;

	localparam int N_SYS   = 2;
	localparam int N_WORDS = N_SYS * `GS_WORDS_PER_MAT;
	localparam int N_RES   = N_SYS * `GS_N;
	localparam int TIMEOUT = N_SYS * `GS_ITERS * `GS_N * 8 + 200;

	logic                         i_clk;
	logic                         i_reset;
	logic                         i_module_en;
	logic [`GS_MATNUM_W-1:0]      i_matrix_num;
	logic                         o_proc_done;
	logic                         o_mem_rreq;
	logic [`GS_MEM_AW-1:0]        o_mem_addr;
	logic [`GS_N*`GS_LANE_W-1:0]  mem_dout;
	logic                         mem_dout_vld;
	logic                         mem_busy;
	logic                         o_x_wen;
	logic [`GS_XADDR_W-1:0]       o_x_addr;
	logic [`GS_X_W-1:0]           o_x_data;

	logic [255:0] tdata [0:N_WORDS+N_RES-1]; // memory words, then expected x
	logic         seen [0:N_RES-1];
	int           wr_count;
	int           row_reads; // row reads since the last b read
	int           cur_sys;
	int           cycles;

	gs_top dut0 (
		.i_clk, .i_reset, .i_module_en, .i_matrix_num, .o_proc_done,
		.o_mem_rreq, .o_mem_addr, .i_mem_dout(mem_dout), .i_mem_dout_vld(mem_dout_vld),
		.o_x_wen, .o_x_addr, .o_x_data
	);

	tb_gs_mem mem0 (
		.i_clk, .i_rreq(o_mem_rreq), .i_addr(o_mem_addr),
		.o_dout(mem_dout), .o_dout_vld(mem_dout_vld), .o_busy(mem_busy)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		assert (cycles < TIMEOUT) else begin
			$display("timeout: solver did not finish within %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

	// ------------------------------------------------------------
	// bus monitor, sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge i_clk) begin
		int a;
		if (!i_reset) begin
			// result first, a request in the same cycle belongs to the next row
			if (o_x_wen) begin
				a = int'(o_x_addr);
				wr_count++;
				assert (a < N_RES && a / `GS_N == cur_sys) else begin
					$display("MISMATCH o_x_addr got=%h system=%h", o_x_addr, cur_sys);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				assert (!seen[a]) else begin
					$display("result address %h written twice", o_x_addr);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				assert (row_reads > (`GS_ITERS - 1) * `GS_N) else begin
					$display("result written before the final sweep, address %h", o_x_addr);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				assert (o_x_data == tdata[N_WORDS+a][31:0]) else begin
					$display("MISMATCH o_x_data addr=%h got=%h exp=%h",
						o_x_addr, o_x_data, tdata[N_WORDS+a][31:0]);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				seen[a] = 1'b1;
			end
			if (o_mem_rreq) begin
				assert (!mem_busy) else begin
					$display("read request issued while a read was still outstanding");
					$display("RESULT: FAIL");
					$fatal(1);
				end
				assert (o_mem_addr < N_WORDS) else begin
					$display("read address %h lies outside the matrix memory", o_mem_addr);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				if (o_mem_addr % `GS_WORDS_PER_MAT == 0) begin // b word
					cur_sys   = o_mem_addr / `GS_WORDS_PER_MAT;
					row_reads = 0;
				end else begin
					row_reads++;
				end
			end
			assert (!o_proc_done || wr_count == N_RES) else begin
				$display("o_proc_done high after only %0d results", wr_count);
				$display("RESULT: FAIL");
				$fatal(1);
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		i_reset      = 1'b1;
		i_module_en  = 1'b0;
		i_matrix_num = '0;
		wr_count     = 0;
		row_reads    = 0;
		cur_sys      = 0;
		cycles       = 0;
		for (int k = 0; k < N_RES; k++)
			seen[k] = 1'b0;
		$readmemh("test/gs_testdata.hex", tdata);
		for (int k = 0; k < N_WORDS; k++)
			mem0.words[k] = tdata[k];

		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);
		i_matrix_num = N_SYS;
		i_module_en  = 1'b1;

		while (!o_proc_done)
			@(negedge i_clk);

		repeat (5) begin
			@(negedge i_clk);
			assert (o_proc_done) else begin
				$display("o_proc_done dropped while i_module_en was held");
				$display("RESULT: FAIL");
				$fatal(1);
			end
		end
		assert (wr_count == N_RES) else begin
			$display("MISMATCH write count got=%h exp=%h", wr_count, N_RES);
			$display("RESULT: FAIL");
			$fatal(1);
		end

		i_module_en = 1'b0;
		@(negedge i_clk);
		assert (!o_proc_done) else begin
			$display("o_proc_done still high one cycle after i_module_en fell");
			$display("RESULT: FAIL");
			$fatal(1);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/gs_ctrl_pkg.sv ====
// solver control types
`default_nettype none
`include "gs_macros.svh"

package gs_ctrl_pkg;

	typedef enum logic [2:0] {
		S_IDLE, S_B_REQ, S_B_WAIT, S_ROW_REQ, S_ROW_WAIT, S_ROW_CALC, S_FINISH
	} gs_state_t;

	typedef struct packed {
		logic [$clog2(`GS_N)-1:0]   row;
		logic [$clog2(`GS_ITERS):0] iter;
		logic [`GS_MATNUM_W-1:0]    mat;
	} gs_idx_t;

	typedef struct packed {
		logic [$clog2(`GS_N)-1:0] row;
		gs_num_pkg::x_t           x; // new unknown, Q16.16
	} gs_upd_t;

endpackage

`default_nettype wire

// ==== verilog/gs_fsm.sv ====
// solver sequencing FSM
`timescale 1ns/1ps
`default_nettype none

module gs_fsm (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_module_en,
	input  logic i_mem_dout_vld,
	input  logic i_upd,
	input  logic i_last_row, // final row of the final sweep
	input  logic i_all_done,
	output logic o_rreq,
	output logic o_load_b,
	output logic o_row_vld,
	output logic o_proc_done
);

	gs_ctrl_pkg::gs_state_t state, state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			gs_ctrl_pkg::S_IDLE:     if (i_module_en) state_nxt = gs_ctrl_pkg::S_B_REQ;
			gs_ctrl_pkg::S_B_REQ:    state_nxt = gs_ctrl_pkg::S_B_WAIT;
			gs_ctrl_pkg::S_B_WAIT:   if (i_mem_dout_vld) state_nxt = gs_ctrl_pkg::S_ROW_REQ;
			gs_ctrl_pkg::S_ROW_REQ:  state_nxt = gs_ctrl_pkg::S_ROW_WAIT;
			gs_ctrl_pkg::S_ROW_WAIT: if (i_mem_dout_vld) state_nxt = gs_ctrl_pkg::S_ROW_CALC;
			gs_ctrl_pkg::S_ROW_CALC: begin
				if (i_upd) begin
					if (i_all_done)
						state_nxt = gs_ctrl_pkg::S_FINISH;
					else if (i_last_row)
						state_nxt = gs_ctrl_pkg::S_B_REQ; // next system
					else
						state_nxt = gs_ctrl_pkg::S_ROW_REQ;
				end
			end
			gs_ctrl_pkg::S_FINISH:   if (!i_module_en) state_nxt = gs_ctrl_pkg::S_IDLE;
			default:                 state_nxt = gs_ctrl_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			state <= gs_ctrl_pkg::S_IDLE;
		else
			state <= state_nxt;
	end

	assign o_rreq      = (state == gs_ctrl_pkg::S_B_REQ) || (state == gs_ctrl_pkg::S_ROW_REQ);
	assign o_load_b    = (state == gs_ctrl_pkg::S_B_WAIT) && i_mem_dout_vld;
	assign o_row_vld   = (state == gs_ctrl_pkg::S_ROW_WAIT) && i_mem_dout_vld;
	assign o_proc_done = (state == gs_ctrl_pkg::S_FINISH);

	// memory answers only the single outstanding read
	a_vld_in_wait: assert property (@(posedge i_clk) disable iff (i_reset)
		i_mem_dout_vld |-> (state == gs_ctrl_pkg::S_B_WAIT || state == gs_ctrl_pkg::S_ROW_WAIT));

endmodule

`default_nettype wire

// ==== verilog/gs_index_counter.sv ====
// row, sweep and system counters
`timescale 1ns/1ps
`default_nettype none
`include "gs_macros.svh"

module gs_index_counter (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic                         i_start, // run level, counters clear while low
	input  logic                         i_upd,
	input  logic                         i_load_b,
	input  logic [`GS_MATNUM_W-1:0]      i_matrix_num,
	output gs_ctrl_pkg::gs_idx_t         o_idx,
	output logic                         o_last_row,
	output logic                         o_last_iter,
	output logic                         o_all_done,
	output logic [`GS_MEM_AW-1:0]        o_mem_addr
);

	logic                  need_b; // next read is the b word
	logic                  row_end;
	logic [`GS_MEM_AW-1:0] base;

	assign row_end     = (o_idx.row == `GS_N-1);
	assign o_last_iter = (o_idx.iter == `GS_ITERS-1);
	assign o_last_row  = row_end && o_last_iter;
	assign o_all_done  = o_last_row && (o_idx.mat == i_matrix_num - 1'b1);

	assign base       = `GS_MEM_AW'(o_idx.mat * `GS_WORDS_PER_MAT);
	assign o_mem_addr = need_b ? base : base + `GS_MEM_AW'(o_idx.row) + 1'b1;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_idx  <= '0;
			need_b <= 1'b1;
		end else if (!i_start) begin
			o_idx  <= '0;
			need_b <= 1'b1;
		end else begin
			if (i_load_b)
				need_b <= 1'b0;
			if (i_upd) begin
				o_idx.row <= row_end ? '0 : o_idx.row + 1'b1;
				if (o_last_row) begin
					o_idx.iter <= '0;
					o_idx.mat  <= o_all_done ? '0 : o_idx.mat + 1'b1;
					need_b     <= 1'b1; // system finished, fetch next b
				end else if (row_end) begin
					o_idx.iter <= o_idx.iter + 1'b1;
				end
			end
		end
	end

	// b word arrives only when a system restarts at row 0 of sweep 0
	a_b_at_start: assert property (@(posedge i_clk) disable iff (i_reset)
		i_load_b |-> (o_idx.row == '0 && o_idx.iter == '0));

endmodule

`default_nettype wire

// ==== verilog/gs_macros.svh ====
// solver size and format constants
`ifndef GS_MACROS_SVH
`define GS_MACROS_SVH

`define GS_N             16 // unknowns per system
`define GS_ITERS         16 // sweeps per system
`define GS_WORDS_PER_MAT 17 // b word plus one word per row
`define GS_LANE_W        16
`define GS_X_W           32 // Q16.16
`define GS_FRAC_B        16 // b integer into Q16.16
`define GS_FRAC_INV      14 // reciprocal is Q2.14
`define GS_ACC_W         53 // b term plus 15 products, no overflow
`define GS_MEM_AW        10
`define GS_XADDR_W       9
`define GS_MATNUM_W      5

`endif

// ==== verilog/gs_num_pkg.sv ====
// fixed-point number types
`default_nettype none
`include "gs_macros.svh"

package gs_num_pkg;

	typedef logic signed [`GS_LANE_W-1:0] lane_t;
	typedef lane_t [`GS_N-1:0]            mem_word_t; // b word and row words alike
	typedef logic signed [`GS_X_W-1:0]    x_t;
	typedef x_t [`GS_N-1:0]               x_vec_t;
	typedef logic signed [`GS_ACC_W-1:0]  acc_t;

	// clamp to 0x80000000 .. 0x7fffffff
	function automatic x_t sat_x(input acc_t v);
		logic ovf;
		ovf = (v[`GS_ACC_W-1:`GS_X_W-1] != {(`GS_ACC_W-`GS_X_W+1){v[`GS_ACC_W-1]}});
		if (!ovf)
			sat_x = v[`GS_X_W-1:0];
		else if (v[`GS_ACC_W-1])
			sat_x = {1'b1, {(`GS_X_W-1){1'b0}}}; // negative overflow
		else
			sat_x = {1'b0, {(`GS_X_W-1){1'b1}}}; // positive overflow
	endfunction

endpackage

`default_nettype wire

// ==== verilog/gs_row_unit.sv ====
// row update pipeline
`timescale 1ns/1ps
`default_nettype none
`include "gs_macros.svh"

module gs_row_unit (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_row_vld,
	input  gs_num_pkg::mem_word_t    i_mem_dout,
	input  logic [$clog2(`GS_N)-1:0] i_row,
	input  gs_num_pkg::x_vec_t       i_x_vec,
	input  gs_num_pkg::mem_word_t    i_b_vec,
	output logic                     o_upd,
	output gs_ctrl_pkg::gs_upd_t     o_upd_data
);

	// ------------------------------------------------------------
	// stage one: b_i << 16 minus off-diagonal dot product
	// ------------------------------------------------------------
	gs_num_pkg::acc_t         dot;
	logic                     s1_vld;
	gs_num_pkg::x_t           s1_acc;
	gs_num_pkg::lane_t        s1_inv; // Q2.14 reciprocal of a_ii
	logic [$clog2(`GS_N)-1:0] s1_row;

	always_comb begin
		dot = gs_num_pkg::acc_t'($signed(i_b_vec[i_row])) <<< `GS_FRAC_B;
		for (int j = 0; j < `GS_N; j++) begin
			if (j != i_row)
				dot = dot - $signed(i_mem_dout[j]) * $signed(i_x_vec[j]);
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			s1_vld <= 1'b0;
		else
			s1_vld <= i_row_vld;
	end

	always_ff @(posedge i_clk) begin
		if (i_row_vld) begin
			s1_acc <= gs_num_pkg::sat_x(dot);
			s1_inv <= i_mem_dout[i_row]; // diagonal lane
			s1_row <= i_row;
		end
	end

	// ------------------------------------------------------------
	// stage two: scale by reciprocal
	// ------------------------------------------------------------
	gs_num_pkg::acc_t scaled;

	assign scaled = (gs_num_pkg::acc_t'(s1_acc) * gs_num_pkg::acc_t'(s1_inv)) >>> `GS_FRAC_INV;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			o_upd <= 1'b0;
		else
			o_upd <= s1_vld;
	end

	always_ff @(posedge i_clk) begin
		if (s1_vld) begin
			o_upd_data.row <= s1_row;
			o_upd_data.x   <= gs_num_pkg::sat_x(scaled);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/gs_top.sv ====
// Gauss-Seidel solver top
`timescale 1ns/1ps
`default_nettype none
`include "gs_macros.svh"

module gs_top (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic                         i_module_en,
	input  logic [`GS_MATNUM_W-1:0]      i_matrix_num,
	output logic                         o_proc_done,

	// matrix memory
	output logic                         o_mem_rreq,
	output logic [`GS_MEM_AW-1:0]        o_mem_addr,
	input  logic [`GS_N*`GS_LANE_W-1:0]  i_mem_dout,
	input  logic                         i_mem_dout_vld,

	// results
	output logic                         o_x_wen,
	output logic [`GS_XADDR_W-1:0]       o_x_addr,
	output logic [`GS_X_W-1:0]           o_x_data
);

	logic                  load_b, row_vld, upd;
	logic                  last_row, last_iter, all_done;
	gs_ctrl_pkg::gs_idx_t  idx;
	gs_ctrl_pkg::gs_upd_t  upd_data;
	gs_num_pkg::x_vec_t    x_vec;
	gs_num_pkg::mem_word_t b_vec;

	gs_fsm fsm0 (
		.i_clk, .i_reset, .i_module_en, .i_mem_dout_vld,
		.i_upd(upd), .i_last_row(last_row), .i_all_done(all_done),
		.o_rreq(o_mem_rreq), .o_load_b(load_b), .o_row_vld(row_vld), .o_proc_done
	);

	gs_index_counter cnt0 (
		.i_clk, .i_reset, .i_start(i_module_en), .i_upd(upd), .i_load_b(load_b),
		.i_matrix_num, .o_idx(idx), .o_last_row(last_row), .o_last_iter(last_iter),
		.o_all_done(all_done), .o_mem_addr
	);

	gs_row_unit row0 (
		.i_clk, .i_reset, .i_row_vld(row_vld), .i_mem_dout, .i_row(idx.row),
		.i_x_vec(x_vec), .i_b_vec(b_vec), .o_upd(upd), .o_upd_data(upd_data)
	);

	gs_vector_store store0 (
		.i_clk, .i_reset, .i_load_b(load_b), .i_mem_dout, .i_upd(upd),
		.i_upd_data(upd_data), .i_idx(idx), .i_last_iter(last_iter),
		.o_x_vec(x_vec), .o_b_vec(b_vec), .o_x_wen, .o_x_addr, .o_x_data
	);

endmodule

`default_nettype wire

// ==== verilog/gs_vector_store.sv ====
// b and x storage with result port
`timescale 1ns/1ps
`default_nettype none
`include "gs_macros.svh"

module gs_vector_store (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_load_b,
	input  gs_num_pkg::mem_word_t   i_mem_dout,
	input  logic                    i_upd,
	input  gs_ctrl_pkg::gs_upd_t    i_upd_data,
	input  gs_ctrl_pkg::gs_idx_t    i_idx,
	input  logic                    i_last_iter,
	output gs_num_pkg::x_vec_t      o_x_vec,
	output gs_num_pkg::mem_word_t   o_b_vec,
	output logic                    o_x_wen,
	output logic [`GS_XADDR_W-1:0]  o_x_addr,
	output gs_num_pkg::x_t          o_x_data
);

	// new system: take b, restart every unknown at zero
	always_ff @(posedge i_clk) begin
		if (i_load_b) begin
			o_b_vec <= i_mem_dout;
			o_x_vec <= '0;
		end else if (i_upd) begin
			o_x_vec[i_upd_data.row] <= i_upd_data.x;
		end
	end

	// ------------------------------------------------------------
	// result port, final sweep only
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			o_x_wen <= 1'b0;
		else
			o_x_wen <= i_upd && i_last_iter;
	end

	always_ff @(posedge i_clk) begin
		if (i_upd) begin
			o_x_addr <= {i_idx.mat, i_upd_data.row}; // mat*16 + row
			o_x_data <= i_upd_data.x;
		end
	end

	// counter must still point at the row the pipeline finished
	a_wen_last_iter: assert property (@(posedge i_clk) disable iff (i_reset)
		o_x_wen |-> $past(i_last_iter && (i_idx.row == i_upd_data.row)));

endmodule

`default_nettype wire
